// ==== common/systolic_pkg.sv ====
/*
  Shared element types and APB register map of the systolic matrix multiplier.
  Imported by the RTL and the testbench.
*/
package systolic_pkg;

  typedef logic signed [7:0] operand_t; // A and B elements
  typedef logic signed [31:0] acc_t; // accumulator and C elements

  // control register
  // write bit 0 = 1 while idle to start a run, reads back as zero
  localparam logic [11:0] ctrl_addr = 12'h000;

  // status register, read only
  // bit 0 busy, bit 1 done (sticky until the next start)
  localparam logic [11:0] status_addr = 12'h004;

  // element windows, element (row, col) at base + 4 * (row * n + col)
  // A and B are write only, C is read only
  localparam logic [11:0] a_base = 12'h100;
  localparam logic [11:0] b_base = 12'h200;
  localparam logic [11:0] c_base = 12'h300;

endpackage

// ==== array/pe.sv ====
/*
  One multiply-accumulate cell. Forwards A right and B down, one cycle
  per hop, and keeps its own running sum.
*/
`timescale 1ns/1ps

module pe (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear,
  input  systolic_pkg::operand_t a_in,
  input  systolic_pkg::operand_t b_in,
  output systolic_pkg::operand_t a_out,
  output systolic_pkg::operand_t b_out,
  output systolic_pkg::acc_t     sum
);

  logic signed [15:0] prod;

  assign prod = a_in * b_in; // full signed 8x8 product

  always_ff @(posedge clk) begin
    if (reset) begin
      a_out <= '0;
      b_out <= '0;
      sum   <= '0;
    end else begin
      a_out <= a_in;
      b_out <= b_in;
      if (clear) sum <= '0; // new run
      else sum <= sum + {{16{prod[15]}}, prod};
    end
  end

endmodule

// ==== array/systolic_array.sv ====
/*
  Output-stationary n x n grid of MAC cells. A rows enter on the left,
  B columns on the top, gated by the registered bank enables.
*/
`timescale 1ns/1ps

module systolic_array #(
  parameter int n = 4
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   clear,
  input  logic [n-1:0]           rd_en,
  input  systolic_pkg::operand_t a_data [n],
  input  systolic_pkg::operand_t b_data [n],
  output systolic_pkg::acc_t     sums [n][n]
);
  import systolic_pkg::*;

  logic [n-1:0] valid; // rd_en aligned with registered bank data
  operand_t     a_h [n][n+1]; // last column falls off the right edge
  operand_t     b_v [n+1][n];

  always_ff @(posedge clk) begin
    if (reset) valid <= '0;
    else valid <= rd_en;
  end

  for (genvar i = 0; i < n; i++) begin : g_edge
    assign a_h[i][0] = valid[i] ? a_data[i] : '0; // zeros outside the feed window
    assign b_v[0][i] = valid[i] ? b_data[i] : '0;
  end

  for (genvar r = 0; r < n; r++) begin : g_row
    for (genvar c = 0; c < n; c++) begin : g_col
      pe u_pe (
        .clk, .reset, .clear,
        .a_in(a_h[r][c]), .b_in(b_v[r][c]),
        .a_out(a_h[r][c+1]), .b_out(b_v[r+1][c]),
        .sum(sums[r][c])
      );
    end
  end

endmodule

// ==== array/rd_control.sv ====
/*
  Skewed read controller for the operand banks. After start the bank
  enables grow one bank per cycle, then drop from the low end, and each
  enabled bank steps its address. Pulses wr_active once the array has drained.
*/
`timescale 1ns/1ps

module rd_control #(
  parameter int n = 4,
  localparam int aw = $clog2(n)
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          start,
  output logic [n-1:0]  rd_en,
  output logic [aw-1:0] rd_addr [n],
  output logic          wr_active
);
  localparam int cw = $clog2(3 * n);

  typedef enum logic [1:0] {idle, grow, shrink, drain} state_t;

  state_t        state;
  logic [cw-1:0] cnt; // cycles since the first nonzero rd_en

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= idle;
      rd_en     <= '0;
      cnt       <= '0;
      wr_active <= 1'b0;
    end else begin
      wr_active <= 1'b0;
      cnt       <= cnt + 1'b1;
      case (state)
        idle: begin
          cnt <= '0;
          if (start) begin
            rd_en <= n'(1); // bank 0 first
            state <= grow;
          end
        end
        grow: begin
          if (&rd_en) begin
            rd_en <= rd_en << 1; // full staircase, start dropping
            state <= shrink;
          end else begin
            rd_en <= {rd_en[n-2:0], 1'b1};
          end
        end
        shrink: begin
          rd_en <= rd_en << 1;
          if (rd_en[n-2:0] == '0) state <= drain;
        end
        default: begin // drain, wait for the last cell to settle
          if (cnt == cw'(3 * n - 1)) begin
            wr_active <= 1'b1;
            state     <= idle;
          end
        end
      endcase
    end
  end

  // per-bank address counters
  always_ff @(posedge clk) begin
    for (int i = 0; i < n; i++) begin
      if (reset || state == idle || state == drain) rd_addr[i] <= '0;
      else if (rd_en[i]) rd_addr[i] <= rd_addr[i] + 1'b1;
    end
  end

endmodule

// ==== logic/mem_arr.sv ====
/*
  n independent banks of depth n with a shared write address and
  per-bank registered reads. Serves operand and result payloads via elem_t.
*/
`timescale 1ns/1ps

module mem_arr #(
  parameter int  n      = 4,
  parameter type elem_t = logic [7:0],
  localparam int aw     = $clog2(n)
) (
  input  logic          clk,
  input  logic [n-1:0]  wr_en,
  input  logic [aw-1:0] wr_addr,
  input  elem_t         wr_data [n],
  input  logic [n-1:0]  rd_en,
  input  logic [aw-1:0] rd_addr [n],
  output elem_t         rd_data [n]
);

  for (genvar i = 0; i < n; i++) begin : g_bank
    elem_t mem [n] = '{default: '0}; // banks power up cleared
    elem_t rd_q = '0;

    always_ff @(posedge clk) begin
      if (wr_en[i]) mem[wr_addr] <= wr_data[i];
      if (rd_en[i]) rd_q <= mem[rd_addr[i]]; // holds last word otherwise
    end

    assign rd_data[i] = rd_q;
  end

endmodule

// ==== logic/wr_control.sv ====
/*
  Copies the drained array sums into the result banks, one row per cycle,
  then pulses done for the register block.
*/
`timescale 1ns/1ps

module wr_control #(
  parameter int n = 4,
  localparam int aw = $clog2(n)
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               wr_active,
  input  systolic_pkg::acc_t sums [n][n],
  output logic [n-1:0]       c_wr_en,
  output logic [aw-1:0]      c_wr_addr,
  output systolic_pkg::acc_t c_wr_data [n],
  output logic               done
);

  logic          active;
  logic [aw-1:0] row; // row being written this cycle

  always_ff @(posedge clk) begin
    if (reset) begin
      active <= 1'b0;
      row    <= '0;
      done   <= 1'b0;
    end else begin
      done <= 1'b0;
      if (wr_active) begin
        active <= 1'b1;
        row    <= '0;
      end else if (active) begin
        if (row == aw'(n - 1)) begin
          active <= 1'b0;
          row    <= '0;
          done   <= 1'b1; // cycle after the last row
        end else begin
          row <= row + 1'b1;
        end
      end
    end
  end

  // every bank written at once, bank c takes column c
  assign c_wr_en   = {n{active}};
  assign c_wr_addr = row;

  always_comb begin
    for (int c = 0; c < n; c++) begin
      c_wr_data[c] = sums[row][c];
    end
  end

endmodule

// ==== logic/apb_regs.sv ====
/*
  APB slave without wait states: control and status registers plus the
  A, B and C element windows. Operand writes go straight to one bank,
  C reads are issued in setup and returned in access.
*/
`timescale 1ns/1ps

module apb_regs #(
  parameter int n = 4,
  localparam int aw = $clog2(n)
) (
  input  logic                clk,
  input  logic                reset,
  input  logic [11:0]         paddr,
  input  logic                psel,
  input  logic                penable,
  input  logic                pwrite,
  input  logic [31:0]         pwdata,
  input  logic                done,
  output logic [31:0]         prdata,
  output logic                pready,
  output logic                pslverr,
  output logic                start,
  output logic [n-1:0]        a_wr_en,
  output logic [n-1:0]        b_wr_en,
  output logic [aw-1:0]       op_wr_addr,
  output systolic_pkg::operand_t op_wr_data [n],
  output logic [n-1:0]        c_rd_en,
  output logic [aw-1:0]       c_rd_addr [n],
  input  systolic_pkg::acc_t  c_rd_data [n]
);
  import systolic_pkg::*;

  logic          setup, access, busy, done_flag;
  logic          ctrl_sel, status_sel, a_sel, b_sel, c_sel, in_range, mapped;
  logic [5:0]    idx; // word index inside a window
  logic [aw-1:0] row, col;

  assign setup  = psel & ~penable;
  assign access = psel & penable;
  assign pready = 1'b1;

  assign idx      = paddr[7:2];
  assign in_range = (paddr[1:0] == 2'b00) && (idx < n * n);
  assign row      = aw'(idx / n);
  assign col      = aw'(idx % n);

  assign ctrl_sel   = (paddr == ctrl_addr);
  assign status_sel = (paddr == status_addr);
  assign a_sel      = (paddr[11:8] == a_base[11:8]) && in_range;
  assign b_sel      = (paddr[11:8] == b_base[11:8]) && in_range;
  assign c_sel      = (paddr[11:8] == c_base[11:8]) && in_range;
  assign mapped     = ctrl_sel | status_sel | a_sel | b_sel | c_sel;

  assign pslverr = access & (~mapped | (pwrite & (c_sel | status_sel))
                             | (pwrite & busy & (a_sel | b_sel)));

  assign start = access & pwrite & ctrl_sel & pwdata[0] & ~busy; // ignored while busy

  // A bank = row, addr = col; B bank = col, addr = row
  assign a_wr_en    = (access & pwrite & ~busy & a_sel) ? n'(1) << row : '0;
  assign b_wr_en    = (access & pwrite & ~busy & b_sel) ? n'(1) << col : '0;
  assign op_wr_addr = b_sel ? row : col;

  // result bank read launched in setup so data is registered by access
  assign c_rd_en = (setup & ~pwrite & c_sel) ? n'(1) << col : '0;

  always_comb begin
    for (int i = 0; i < n; i++) begin
      op_wr_data[i] = pwdata[7:0];
      c_rd_addr[i]  = row;
    end
  end

  always_comb begin
    prdata = '0;
    if (status_sel) prdata = {30'b0, done_flag, busy};
    else if (c_sel) prdata = c_rd_data[col];
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      busy      <= 1'b0;
      done_flag <= 1'b0;
    end else if (start) begin
      busy      <= 1'b1;
      done_flag <= 1'b0;
    end else if (done) begin
      busy      <= 1'b0;
      done_flag <= 1'b1; // sticky until next start
    end
  end

endmodule

// ==== logic/systolic_mm_top.sv ====
/*
  Top level of the APB systolic matrix multiplier.
  The host loads A and B, starts a run, polls status and reads C = A x B.
*/
`timescale 1ns/1ps

module systolic_mm_top #(
  parameter int n = 4
) (
  input  logic        clk,
  input  logic        reset,
  input  logic [11:0] paddr,
  input  logic        psel,
  input  logic        penable,
  input  logic        pwrite,
  input  logic [31:0] pwdata,
  output logic [31:0] prdata,
  output logic        pready,
  output logic        pslverr
);
  import systolic_pkg::*;

  localparam int aw = $clog2(n);

  logic           start, done, wr_active;
  logic [n-1:0]   a_wr_en, b_wr_en, c_rd_en, rd_en, c_wr_en;
  logic [aw-1:0]  op_wr_addr, c_wr_addr;
  logic [aw-1:0]  c_rd_addr [n];
  logic [aw-1:0]  rd_addr [n];
  operand_t       op_wr_data [n];
  operand_t       a_rd_data [n];
  operand_t       b_rd_data [n];
  acc_t           c_rd_data [n];
  acc_t           c_wr_data [n];
  acc_t           sums [n][n];

  apb_regs #(.n(n)) u_apb_regs (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr, .done, .start,
    .a_wr_en, .b_wr_en, .op_wr_addr, .op_wr_data,
    .c_rd_en, .c_rd_addr, .c_rd_data
  );

  // A banks hold rows, B banks hold columns, both read by the staircase
  mem_arr #(.n(n), .elem_t(operand_t)) u_a_mem (
    .clk, .wr_en(a_wr_en), .wr_addr(op_wr_addr), .wr_data(op_wr_data),
    .rd_en, .rd_addr, .rd_data(a_rd_data)
  );

  mem_arr #(.n(n), .elem_t(operand_t)) u_b_mem (
    .clk, .wr_en(b_wr_en), .wr_addr(op_wr_addr), .wr_data(op_wr_data),
    .rd_en, .rd_addr, .rd_data(b_rd_data)
  );

  mem_arr #(.n(n), .elem_t(acc_t)) u_c_mem ( // bank c holds column c of the result
    .clk, .wr_en(c_wr_en), .wr_addr(c_wr_addr), .wr_data(c_wr_data),
    .rd_en(c_rd_en), .rd_addr(c_rd_addr), .rd_data(c_rd_data)
  );

  rd_control #(.n(n)) u_rd_control (
    .clk, .reset, .start, .rd_en, .rd_addr, .wr_active
  );

  systolic_array #(.n(n)) u_systolic_array (
    .clk, .reset, .clear(start), .rd_en, .a_data(a_rd_data), .b_data(b_rd_data), .sums
  );

  wr_control #(.n(n)) u_wr_control (
    .clk, .reset, .wr_active, .sums, .c_wr_en, .c_wr_addr, .c_wr_data, .done
  );

endmodule

// ==== dv/systolic_mm_tb.sv ====
/*
  Testbench for the APB systolic matrix multiplier. Loads A and B over APB,
  starts runs, polls status and compares C with a reference multiply.
*/
`timescale 1ns/1ps

module systolic_mm_tb;
  import systolic_pkg::*;

  localparam int n = 4;
  localparam int num_tests = 5;
  localparam int watchdog_ns = num_tests * (2 * n * n + 60 + n * n) * 3 * 20;

  logic        clk;
  logic        reset;
  logic [11:0] paddr;
  logic        psel;
  logic        penable;
  logic        pwrite;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic        pready;
  logic        pslverr;

  operand_t    a_m [n][n]; // host copies of the operands
  operand_t    b_m [n][n];
  acc_t        c_exp [n][n];
  logic [31:0] seed = 32'hba88_559f;
  int          pass_cnt = 0;
  int          fail_cnt = 0;
  int          test_fails = 0; // fail count when the current test began

  systolic_mm_top #(.n(n)) u_systolic_mm_top (
    .clk, .reset, .paddr, .psel, .penable, .pwrite, .pwdata,
    .prdata, .pready, .pslverr
  );

  initial clk = 1'b0;
  always #10 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    seed = seed * 32'd1664525 + 32'd1013904223;
    return seed;
  endfunction

  function automatic operand_t rand_operand();
    logic [31:0] r;
    r = lcg_next();
    return operand_t'(r[23:16]); // upper bits have the better period
  endfunction

  // plain triple loop in 32-bit signed arithmetic
  function automatic void ref_matmul(input operand_t a [n][n], input operand_t b [n][n],
                                     output acc_t c [n][n]);
    acc_t s;
    for (int r = 0; r < n; r++) begin
      for (int col = 0; col < n; col++) begin
        s = '0;
        for (int k = 0; k < n; k++) s += acc_t'(a[r][k]) * acc_t'(b[k][col]);
        c[r][col] = s;
      end
    end
  endfunction

  function automatic logic [11:0] elem_addr(input logic [11:0] base, input int r, input int c);
    return base + 12'(4 * (r * n + c));
  endfunction

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      fail_cnt++;
    end else begin
      pass_cnt++;
    end
  endtask

  // both tasks start and end 1 ns after a rising edge
  task automatic apb_write(input logic [11:0] addr, input logic [31:0] data, output logic err);
    paddr   = addr;
    pwdata  = data;
    pwrite  = 1'b1;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);
    err = pslverr; // mid access cycle
    check("pready", 32'(pready), 32'h1);
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_read(input logic [11:0] addr, output logic [31:0] data, output logic err);
    paddr   = addr;
    pwrite  = 1'b0;
    psel    = 1'b1;
    penable = 1'b0;
    @(posedge clk);
    #1 penable = 1'b1;
    @(negedge clk);
    data = prdata;
    err  = pslverr;
    check("pready", 32'(pready), 32'h1);
    @(posedge clk);
    #1 psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic load_operands();
    logic err;
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        apb_write(elem_addr(a_base, r, c), 32'(a_m[r][c]), err);
        check("pslverr", 32'(err), 32'h0);
        apb_write(elem_addr(b_base, r, c), 32'(b_m[r][c]), err);
        check("pslverr", 32'(err), 32'h0);
      end
    end
  endtask

  task automatic start_run();
    logic err;
    apb_write(ctrl_addr, 32'h1, err);
    check("pslverr", 32'(err), 32'h0);
  endtask

  task automatic wait_done();
    logic [31:0] st;
    logic        err;
    int          polls;
    st    = '0;
    polls = 0;
    while (!st[1] && polls < 60) begin
      apb_read(status_addr, st, err);
      polls++;
    end
    if (!st[1]) begin
      $display("ERROR t=%0t done flag never came up after %0d status polls", $time, polls);
      fail_cnt++;
    end
  endtask

  task automatic check_result();
    logic [31:0] d;
    logic        err;
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        apb_read(elem_addr(c_base, r, c), d, err);
        check($sformatf("c[%0d][%0d]", r, c), d, c_exp[r][c]);
        check("pslverr", 32'(err), 32'h0);
      end
    end
  endtask

  task automatic report_test(input string name);
    $display("test %s done, %0d mismatches", name, fail_cnt - test_fails);
    test_fails = fail_cnt;
  endtask

  initial begin
    logic [31:0] d;
    logic        err;
    reset   = 1'b1;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    repeat (3) @(posedge clk);
    #1 reset = 1'b0;

    // idle status and a cleared result bank
    apb_read(status_addr, d, err);
    check("status", d, 32'h0);
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        apb_read(elem_addr(c_base, r, c), d, err);
        check($sformatf("c[%0d][%0d]", r, c), d, 32'h0);
      end
    end
    report_test("after_reset");

    // identity times a ramp gives the ramp back
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        a_m[r][c]   = (r == c) ? 8'sd1 : 8'sd0;
        b_m[r][c]   = operand_t'(r * n + c - 6);
        c_exp[r][c] = acc_t'(b_m[r][c]);
      end
    end
    load_operands();
    start_run();
    wait_done();
    apb_read(status_addr, d, err);
    check("status", d, 32'h2); // done 1, busy 0
    check_result();
    report_test("identity");

    for (int run = 0; run < 3; run++) begin
      for (int r = 0; r < n; r++) begin
        for (int c = 0; c < n; c++) begin
          a_m[r][c] = rand_operand();
          b_m[r][c] = rand_operand();
        end
      end
      a_m[run][0]     = -8'sd128; // extremes of the operand range
      b_m[0][run]     = -8'sd128;
      a_m[n-1][run]   = 8'sd127;
      b_m[run][n-1]   = 8'sd127;
      ref_matmul(a_m, b_m, c_exp);
      load_operands();
      start_run();
      wait_done();
      check_result();
    end
    report_test("random_signed");

    // error responses, then operand writes and a second start while busy
    for (int r = 0; r < n; r++) begin
      for (int c = 0; c < n; c++) begin
        a_m[r][c] = rand_operand();
        b_m[r][c] = rand_operand();
      end
    end
    ref_matmul(a_m, b_m, c_exp);
    load_operands();
    apb_write(12'h400, 32'h0, err);
    check("pslverr", 32'(err), 32'h1);
    apb_read(12'h008, d, err);
    check("pslverr", 32'(err), 32'h1);
    apb_read(elem_addr(c_base, n, 0), d, err); // one past the last element
    check("pslverr", 32'(err), 32'h1);
    apb_write(c_base, 32'h5, err);
    check("pslverr", 32'(err), 32'h1);
    apb_write(status_addr, 32'h3, err);
    check("pslverr", 32'(err), 32'h1);
    start_run();
    apb_write(elem_addr(a_base, 0, 0), 32'h7f, err);
    check("pslverr", 32'(err), 32'h1);
    apb_write(elem_addr(b_base, 1, 2), 32'h80, err);
    check("pslverr", 32'(err), 32'h1);
    apb_write(ctrl_addr, 32'h1, err); // dropped while busy
    check("pslverr", 32'(err), 32'h0);
    wait_done();
    check_result();
    report_test("errors");

    // done holds over reads, clears on the next start
    for (int i = 0; i < 3; i++) begin
      apb_read(status_addr, d, err);
      check("status", d, 32'h2);
    end
    start_run();
    apb_read(status_addr, d, err);
    check("status", d, 32'h1);
    wait_done();
    check_result();
    report_test("sticky_done");

    $display("checks passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the tests did not complete", watchdog_ns);
    $display("TESTS FAILED");
    $finish;
  end

endmodule

// ==== systolic_mm.f ====
common/systolic_pkg.sv
array/pe.sv
array/systolic_array.sv
array/rd_control.sv
logic/mem_arr.sv
logic/wr_control.sv
logic/apb_regs.sv
logic/systolic_mm_top.sv
dv/systolic_mm_tb.sv
